// ==== include/tl_cfg.svh ====
`ifndef TL_CFG_SVH
`define TL_CFG_SVH

// Address and data word width
`define TL_ADDR_W 32

// Tag array index bits, 8 lines
`define TL_INDEX_W 3

// Byte offset within a 16-byte line
`define TL_OFFSET_W 4

// Store buffer entries, keep a power of two
`define TL_SB_DEPTH 4

`endif

// ==== rtl/mem_types_pkg.sv ====
`include "tl_cfg.svh"

package mem_types_pkg;

    // Byte address and data word
    typedef logic [`TL_ADDR_W-1:0] addr_t;
    typedef logic [`TL_ADDR_W-1:0] word_t;

    // Address bits above index and offset
    typedef logic [`TL_ADDR_W-`TL_INDEX_W-`TL_OFFSET_W-1:0] tag_t;

    // Line index into the tag array
    typedef logic [`TL_INDEX_W-1:0] index_t;

    // Store buffer slot number
    typedef logic [$clog2(`TL_SB_DEPTH)-1:0] sb_ptr_t;

endpackage

// ==== rtl/tl_ctrl_pkg.sv ====
package tl_ctrl_pkg;

    // Stall controller states
    typedef enum logic [1:0] {
        TL_IDLE,
        MISS_REQ,
        MISS_RELEASE,
        SB_FULL_WAIT
    } tl_state_e;

endpackage

// ==== rtl/dcache_tag.sv ====
`timescale 1ns/10ps

module dcache_tag (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  mem_types_pkg::index_t lookup_index_i,
    input  mem_types_pkg::tag_t   lookup_tag_i,
    input  logic                  fill_en_i,
    input  mem_types_pkg::index_t fill_index_i,
    input  mem_types_pkg::tag_t   fill_tag_i,
    output logic                  hit_o
);

    import mem_types_pkg::*;

    localparam int NUM_LINES = 2 ** $bits(index_t);

    tag_t                 tag_mem [NUM_LINES];
    logic [NUM_LINES-1:0] valid_q;

    // Valid bits come up clear, tags are don't-care until filled
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (fill_en_i) begin
            valid_q[fill_index_i] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (fill_en_i) begin
            tag_mem[fill_index_i] <= fill_tag_i;
        end
    end

    // Combinational lookup for the same-cycle hazard decision
    assign hit_o = valid_q[lookup_index_i] && (tag_mem[lookup_index_i] == lookup_tag_i);

endmodule

// ==== rtl/sb_alloc.sv ====
`timescale 1ns/10ps
`include "tl_cfg.svh"

module sb_alloc (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   push_i,
    input  logic                   pop_i,
    output mem_types_pkg::sb_ptr_t wr_ptr_o,
    output logic                   full_o
);

    import mem_types_pkg::*;

    // One bit wider than the pointer to hold a full count
    typedef logic [$bits(sb_ptr_t):0] cnt_t;

    sb_ptr_t wr_ptr_q;
    cnt_t    count_q;

    // Write pointer wraps naturally, depth is a power of two
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
        end else if (push_i) begin
            wr_ptr_q <= wr_ptr_q + sb_ptr_t'(1);
        end
    end

    // Occupancy, push and pop together leave it unchanged
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            count_q <= '0;
        end else begin
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + cnt_t'(1);
                2'b01:   count_q <= count_q - cnt_t'(1);
                default: count_q <= count_q;
            endcase
        end
    end

    assign wr_ptr_o = wr_ptr_q;
    assign full_o   = (count_q == cnt_t'(`TL_SB_DEPTH));

endmodule

// ==== rtl/sb_entry.sv ====
`timescale 1ns/10ps

module sb_entry #(
    parameter int SLOT = 0
) (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   push_i,
    input  mem_types_pkg::sb_ptr_t wr_ptr_i,
    input  mem_types_pkg::sb_ptr_t rd_ptr_i,
    input  logic                   pop_i,
    input  mem_types_pkg::addr_t   st_addr_i,
    input  mem_types_pkg::word_t   st_data_i,
    input  mem_types_pkg::addr_t   load_addr_i,
    output logic                   valid_o,
    output mem_types_pkg::addr_t   addr_o,
    output mem_types_pkg::word_t   data_o,
    output logic                   match_o
);

    import mem_types_pkg::*;

    localparam sb_ptr_t MY_SLOT = sb_ptr_t'(SLOT);

    logic  wr_en;
    logic  clr_en;
    logic  valid_q;
    addr_t addr_q;
    word_t data_q;

    assign wr_en  = push_i && (wr_ptr_i == MY_SLOT);
    assign clr_en = pop_i && (rd_ptr_i == MY_SLOT);

    // A write takes priority over a clear of the same slot
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (wr_en) begin
            valid_q <= 1'b1;
        end else if (clr_en) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            addr_q <= st_addr_i;
            data_q <= st_data_i;
        end
    end

    // Word compare, byte offset bits ignored
    assign match_o = valid_q && (addr_q[$bits(addr_t)-1:2] == load_addr_i[$bits(addr_t)-1:2]);

    assign valid_o = valid_q;
    assign addr_o  = addr_q;
    assign data_o  = data_q;

endmodule

// ==== rtl/sb_drain.sv ====
`timescale 1ns/10ps
`include "tl_cfg.svh"

module sb_drain (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic [`TL_SB_DEPTH-1:0] valid_i,
    input  logic [`TL_SB_DEPTH-1:0] match_i,
    input  mem_types_pkg::addr_t   addr_i [`TL_SB_DEPTH],
    input  mem_types_pkg::word_t   data_i [`TL_SB_DEPTH],
    input  logic                   flush_go_i,
    output mem_types_pkg::sb_ptr_t rd_ptr_o,
    output logic                   pop_o,
    output logic                   empty_o,
    output logic                   fwd_hit_o,
    output mem_types_pkg::word_t   fwd_data_o,
    output mem_types_pkg::addr_t   oldest_addr_o,
    output mem_types_pkg::word_t   oldest_data_o
);

    import mem_types_pkg::*;

    sb_ptr_t rd_ptr_q;
    sb_ptr_t scan_slot;

    assign empty_o = ~|valid_i;
    assign pop_o   = flush_go_i && !empty_o;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rd_ptr_q <= '0;
        end else if (pop_o) begin
            rd_ptr_q <= rd_ptr_q + sb_ptr_t'(1);
        end
    end

    // Oldest entry is the flush candidate
    assign oldest_addr_o = addr_i[rd_ptr_q];
    assign oldest_data_o = data_i[rd_ptr_q];

    // Walk from the oldest slot upward; later matches are younger and override
    always_comb begin
        fwd_hit_o  = 1'b0;
        fwd_data_o = '0;
        scan_slot  = rd_ptr_q;
        for (int i = 0; i < `TL_SB_DEPTH; i++) begin
            scan_slot = rd_ptr_q + sb_ptr_t'(i);
            if (match_i[scan_slot]) begin
                fwd_hit_o  = 1'b1;
                fwd_data_o = data_i[scan_slot];
            end
        end
    end

    assign rd_ptr_o = rd_ptr_q;

endmodule

// ==== rtl/tl_stage.sv ====
`timescale 1ns/10ps
`include "tl_cfg.svh"

module tl_stage (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  memop_rd_i,
    input  logic                  memop_wr_i,
    input  mem_types_pkg::addr_t  addr_i,
    input  mem_types_pkg::word_t  st_data_i,
    input  logic                  rf_we_i,
    input  logic [4:0]            rf_waddr_i,
    input  logic                  flush_permit_i,
    input  logic                  mmu_ack_i,
    output logic                  mem_rd_o,
    output logic                  sb_hit_o,
    output mem_types_pkg::word_t  load_data_o,
    output mem_types_pkg::addr_t  mem_addr_o,
    output mem_types_pkg::index_t mem_index_o,
    output logic                  rf_we_o,
    output logic [4:0]            rf_waddr_o,
    output logic                  flush_o,
    output mem_types_pkg::addr_t  flush_addr_o,
    output mem_types_pkg::word_t  flush_data_o,
    output logic                  hazard_o,
    output logic                  mmu_req_o,
    output mem_types_pkg::addr_t  mmu_addr_o
);

    import mem_types_pkg::*;
    import tl_ctrl_pkg::*;

    localparam int LINE_LSB = `TL_INDEX_W + `TL_OFFSET_W;

    tl_state_e state_q;
    tl_state_e state_d;

    // Tag array interface
    tag_t   lookup_tag;
    index_t lookup_index;
    logic   tag_hit;
    logic   fill_en;
    addr_t  miss_addr_q;

    // Store buffer wiring
    logic                    sb_push;
    logic                    sb_pop;
    logic                    sb_full;
    logic                    sb_empty;
    sb_ptr_t                 sb_wr_ptr;
    sb_ptr_t                 sb_rd_ptr;
    logic [`TL_SB_DEPTH-1:0] sb_valid;
    logic [`TL_SB_DEPTH-1:0] sb_match;
    addr_t                   sb_addr [`TL_SB_DEPTH];
    word_t                   sb_data [`TL_SB_DEPTH];
    logic                    fwd_hit;
    word_t                   fwd_data;
    addr_t                   oldest_addr;
    word_t                   oldest_data;

    logic load_miss;
    logic drain_go;

    assign lookup_tag   = addr_i[`TL_ADDR_W-1:LINE_LSB];
    assign lookup_index = addr_i[`TL_OFFSET_W +: `TL_INDEX_W];

    // A load served from the buffer never goes to the memory unit
    assign load_miss = memop_rd_i && !fwd_hit && !tag_hit;

    // Stall decision, same cycle as the operation
    always_comb begin
        case (state_q)
            TL_IDLE:      hazard_o = load_miss || (memop_wr_i && sb_full);
            MISS_REQ:     hazard_o = 1'b1;
            MISS_RELEASE: hazard_o = 1'b1;
            SB_FULL_WAIT: hazard_o = sb_full;
            default:      hazard_o = 1'b0;
        endcase
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            TL_IDLE: begin
                if (load_miss) begin
                    state_d = MISS_REQ;
                end else if (memop_wr_i && sb_full) begin
                    state_d = SB_FULL_WAIT;
                end
            end
            MISS_REQ: begin
                if (mmu_ack_i) begin
                    state_d = MISS_RELEASE;
                end
            end
            MISS_RELEASE: begin
                if (!mmu_ack_i) begin
                    state_d = TL_IDLE;
                end
            end
            SB_FULL_WAIT: begin
                if (!sb_full) begin
                    state_d = TL_IDLE;
                end
            end
            default: state_d = TL_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= TL_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Line-aligned miss address, held through the handshake
    always_ff @(posedge clk_i) begin
        if ((state_q == TL_IDLE) && load_miss) begin
            miss_addr_q <= {addr_i[`TL_ADDR_W-1:`TL_OFFSET_W], {`TL_OFFSET_W{1'b0}}};
        end
    end

    // Request is high for the whole MISS_REQ phase
    assign mmu_req_o  = (state_q == MISS_REQ);
    assign mmu_addr_o = miss_addr_q;
    assign fill_en    = (state_q == MISS_REQ) && mmu_ack_i;

    // Idle slot, or forced drain while a store waits on a full buffer
    assign drain_go = flush_permit_i && !sb_empty &&
                      (((state_q == TL_IDLE) && !memop_rd_i && !memop_wr_i) ||
                       ((state_q == SB_FULL_WAIT) && sb_full));

    assign sb_push = memop_wr_i && !hazard_o;

    dcache_tag dcache_tag_inst (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .lookup_index_i (lookup_index),
        .lookup_tag_i   (lookup_tag),
        .fill_en_i      (fill_en),
        .fill_index_i   (miss_addr_q[`TL_OFFSET_W +: `TL_INDEX_W]),
        .fill_tag_i     (miss_addr_q[`TL_ADDR_W-1:LINE_LSB]),
        .hit_o          (tag_hit)
    );

    sb_alloc sb_alloc_inst (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .push_i   (sb_push),
        .pop_i    (sb_pop),
        .wr_ptr_o (sb_wr_ptr),
        .full_o   (sb_full)
    );

    for (genvar g = 0; g < `TL_SB_DEPTH; g++) begin : g_sb_entry
        sb_entry #(
            .SLOT (g)
        ) sb_entry_inst (
            .clk_i       (clk_i),
            .rst_n_i     (rst_n_i),
            .push_i      (sb_push),
            .wr_ptr_i    (sb_wr_ptr),
            .rd_ptr_i    (sb_rd_ptr),
            .pop_i       (sb_pop),
            .st_addr_i   (addr_i),
            .st_data_i   (st_data_i),
            .load_addr_i (addr_i),
            .valid_o     (sb_valid[g]),
            .addr_o      (sb_addr[g]),
            .data_o      (sb_data[g]),
            .match_o     (sb_match[g])
        );
    end

    sb_drain sb_drain_inst (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .valid_i       (sb_valid),
        .match_i       (sb_match),
        .addr_i        (sb_addr),
        .data_i        (sb_data),
        .flush_go_i    (drain_go),
        .rd_ptr_o      (sb_rd_ptr),
        .pop_o         (sb_pop),
        .empty_o       (sb_empty),
        .fwd_hit_o     (fwd_hit),
        .fwd_data_o    (fwd_data),
        .oldest_addr_o (oldest_addr),
        .oldest_data_o (oldest_data)
    );

    // Stage register, control bits
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            mem_rd_o <= 1'b0;
            sb_hit_o <= 1'b0;
            rf_we_o  <= 1'b0;
            flush_o  <= 1'b0;
        end else begin
            mem_rd_o <= memop_rd_i && !hazard_o;
            sb_hit_o <= memop_rd_i && !hazard_o && fwd_hit;
            rf_we_o  <= rf_we_i && !hazard_o;
            flush_o  <= sb_pop;
        end
    end

    // Stage register, payload
    always_ff @(posedge clk_i) begin
        load_data_o  <= fwd_data;
        mem_addr_o   <= addr_i;
        mem_index_o  <= lookup_index;
        rf_waddr_o   <= rf_waddr_i;
        flush_addr_o <= oldest_addr;
        flush_data_o <= oldest_data;
    end

endmodule

// ==== bench/tl_stage_sva.sv ====
`timescale 1ns/10ps

module tl_stage_sva (
    input logic clk_i,
    input logic rst_n_i,
    input logic mmu_req_i,
    input logic mmu_ack_i,
    input logic hazard_i,
    input logic mem_rd_i,
    input logic rf_we_i,
    input logic flush_i
);

    int fail_count = 0;

    // Request holds until the memory unit answers
    req_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mmu_req_i && !mmu_ack_i |=> mmu_req_i)
    else begin
        $error("mmu_req_o dropped before mmu_ack_i");
        fail_count++;
    end

    // New request only after the previous acknowledge is gone
    req_rise_ack_low: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(mmu_req_i) |-> !mmu_ack_i)
    else begin
        $error("mmu_req_o rose while mmu_ack_i was high");
        fail_count++;
    end

    // A stalled cycle sends nothing to the memory stage
    stall_blocks_stage: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        hazard_i |=> !mem_rd_i && !rf_we_i)
    else begin
        $error("mem_rd_o or rf_we_o high after a hazard cycle");
        fail_count++;
    end

    reset_quiet: assert property (@(posedge clk_i)
        $rose(rst_n_i) |-> !flush_i && !mmu_req_i && !hazard_i)
    else begin
        $error("flush_o, mmu_req_o or hazard_o high right after reset");
        fail_count++;
    end

endmodule

bind tl_stage tl_stage_sva tl_stage_sva_inst (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .mmu_req_i (mmu_req_o),
    .mmu_ack_i (mmu_ack_i),
    .hazard_i  (hazard_o),
    .mem_rd_i  (mem_rd_o),
    .rf_we_i   (rf_we_o),
    .flush_i   (flush_o)
);

// ==== bench/tl_stage_tb.sv ====
`timescale 1ns/10ps
`include "tl_cfg.svh"

module tl_stage_tb;

    import mem_types_pkg::*;

    localparam int LINE_LSB   = `TL_INDEX_W + `TL_OFFSET_W;
    localparam int NUM_LINES  = 2 ** `TL_INDEX_W;
    localparam int WAIT_LIMIT = 200;
    // Stall cycles before a blocked store gets drain permission
    localparam int UNBLOCK_AT = 8;
    // Load outcomes
    localparam int FWD  = 0;
    localparam int HIT  = 1;
    localparam int MISS = 2;

    logic       clk_i;
    logic       rst_n_i;
    logic       memop_rd_i;
    logic       memop_wr_i;
    addr_t      addr_i;
    word_t      st_data_i;
    logic       rf_we_i;
    logic [4:0] rf_waddr_i;
    logic       flush_permit_i;
    logic       mmu_ack_i;
    logic       mem_rd_o;
    logic       sb_hit_o;
    word_t      load_data_o;
    addr_t      mem_addr_o;
    index_t     mem_index_o;
    logic       rf_we_o;
    logic [4:0] rf_waddr_o;
    logic       flush_o;
    addr_t      flush_addr_o;
    word_t      flush_data_o;
    logic       hazard_o;
    logic       mmu_req_o;
    addr_t      mmu_addr_o;

    // Reference model of pending stores and the line table
    addr_t sq_addr [$];
    word_t sq_data [$];
    logic  line_valid [NUM_LINES];
    tag_t  line_tag [NUM_LINES];
    int    miss_count = 0;

    int          hs_count = 0;
    addr_t       last_req_addr;
    int          flush_total = 0;
    int          err_count = 0;
    int          pass_count = 0;
    int          test_count = 0;
    int          test_errs = 0;
    string       test_name = "reset";
    logic [31:0] main_seed = 32'd33;
    logic [31:0] resp_seed = 32'd33;

    tl_stage tl_stage_inst (.*);

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // Linear congruential generator returning the upper half of its state
    function automatic logic [15:0] lcg_next(inout logic [31:0] state);
        state = state * 32'd1103515245 + 32'd12345;
        return state[31:16];
    endfunction

    task automatic abort_run(input string why);
        $display("timeout: %s", why);
        $display("Done: errors found");
        $finish;
    endtask

    task automatic check_val(input string what, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
        assert (exp_v === act_v) else begin
            $display("error %s: %s expected %h, actual %h", test_name, what, exp_v, act_v);
            err_count++;
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errs = err_count;
    endtask

    task automatic end_test();
        test_count++;
        if (err_count == test_errs) begin
            pass_count++;
            $display("test %s: passed", test_name);
        end else begin
            $display("test %s: failed with %0d errors", test_name, err_count - test_errs);
        end
    endtask

    // The youngest buffered store wins over the line table
    function automatic int predict_load(input addr_t a, output word_t fwd);
        int     kind;
        index_t idx;
        idx  = a[`TL_OFFSET_W +: `TL_INDEX_W];
        kind = MISS;
        fwd  = '0;
        for (int i = 0; i < sq_addr.size(); i++) begin
            if (sq_addr[i][31:2] == a[31:2]) begin
                kind = FWD;
                fwd  = sq_data[i];
            end
        end
        if (kind == MISS && line_valid[idx] && line_tag[idx] == a[31:LINE_LSB]) begin
            kind = HIT;
        end
        if (kind == MISS) begin
            line_valid[idx] = 1'b1;
            line_tag[idx]   = a[31:LINE_LSB];
            miss_count++;
        end
        return kind;
    endfunction

    // Returns on the rising edge where the stage takes the operation
    task automatic present_op(input logic rd, input logic wr, input addr_t a,
                              input word_t d, output int stalls);
        int n;
        @(posedge clk_i);
        memop_rd_i <= rd;
        memop_wr_i <= wr;
        addr_i     <= a;
        st_data_i  <= d;
        rf_we_i    <= rd;
        rf_waddr_i <= a[6:2];
        n = 0;
        @(negedge clk_i);
        while (hazard_o && n < WAIT_LIMIT) begin
            n++;
            if (wr && n == UNBLOCK_AT) begin
                @(posedge clk_i);
                flush_permit_i <= 1'b1;
            end
            @(negedge clk_i);
        end
        if (hazard_o) begin
            abort_run("hazard_o stayed high, operation never accepted");
        end
        stalls = n;
        @(posedge clk_i);
    endtask

    task automatic release_op();
        memop_rd_i <= 1'b0;
        memop_wr_i <= 1'b0;
        rf_we_i    <= 1'b0;
        @(negedge clk_i);
    endtask

    task automatic do_load(input addr_t a, output int kind);
        int    stalls;
        int    exp_kind;
        word_t exp_data;
        present_op(1'b1, 1'b0, a, '0, stalls);
        exp_kind = predict_load(a, exp_data);
        release_op();
        if (stalls > 0) begin
            kind = MISS;
        end else if (sb_hit_o) begin
            kind = FWD;
        end else begin
            kind = HIT;
        end
        check_val("load outcome", exp_kind, kind);
        check_val("mem_rd_o", 1, 32'(mem_rd_o));
        check_val("sb_hit_o", 32'(exp_kind == FWD), 32'(sb_hit_o));
        check_val("mem_addr_o", a, mem_addr_o);
        check_val("mem_index_o", 32'(a[`TL_OFFSET_W +: `TL_INDEX_W]), 32'(mem_index_o));
        check_val("rf_we_o", 1, 32'(rf_we_o));
        check_val("rf_waddr_o", 32'(a[6:2]), 32'(rf_waddr_o));
        if (exp_kind == FWD) begin
            check_val("load_data_o", exp_data, load_data_o);
        end
        if (exp_kind == MISS) begin
            check_val("miss address", {a[31:`TL_OFFSET_W], 4'h0}, last_req_addr);
        end
    endtask

    task automatic do_store(input addr_t a, input word_t d, output int stalls);
        present_op(1'b0, 1'b1, a, d, stalls);
        sq_addr.push_back(a);
        sq_data.push_back(d);
        release_op();
        check_val("mem_rd_o after store", 0, 32'(mem_rd_o));
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        @(posedge clk_i);
        flush_permit_i <= 1'b1;
        while (sq_addr.size() != 0 && n < WAIT_LIMIT) begin
            n++;
            @(negedge clk_i);
        end
        if (sq_addr.size() != 0) begin
            abort_run("store buffer never drained");
        end
    endtask

    // Every flush must be the oldest store still in the model queue
    always @(negedge clk_i) begin
        if (rst_n_i && flush_o) begin
            if (sq_addr.size() == 0) begin
                $display("unexpected flush in %s with no pending store", test_name);
                err_count++;
            end else begin
                check_val("flush_addr_o", sq_addr[0], flush_addr_o);
                check_val("flush_data_o", sq_data[0], flush_data_o);
                void'(sq_addr.pop_front());
                void'(sq_data.pop_front());
                flush_total++;
            end
        end
    end

    // Memory unit answering a line request after 1 to 4 cycles
    initial begin
        int          n;
        logic [15:0] r;
        mmu_ack_i = 1'b0;
        forever begin
            @(posedge clk_i);
            if (rst_n_i && mmu_req_o && !mmu_ack_i) begin
                last_req_addr = mmu_addr_o;
                r = lcg_next(resp_seed);
                repeat (1 + int'(r[1:0])) @(posedge clk_i);
                mmu_ack_i <= 1'b1;
                n = 0;
                @(posedge clk_i);
                while (mmu_req_o && n < WAIT_LIMIT) begin
                    n++;
                    @(posedge clk_i);
                end
                if (mmu_req_o) begin
                    abort_run("mmu_req_o never dropped after mmu_ack_i");
                end
                mmu_ack_i <= 1'b0;
                hs_count++;
            end
        end
    end

    initial begin
        int          stalls;
        int          kind;
        int          hs_at;
        int          flushes_at;
        logic [15:0] r;
        addr_t       a;
        word_t       d;
        rst_n_i        = 1'b0;
        memop_rd_i     = 1'b0;
        memop_wr_i     = 1'b0;
        addr_i         = '0;
        st_data_i      = '0;
        rf_we_i        = 1'b0;
        rf_waddr_i     = '0;
        flush_permit_i = 1'b1;
        for (int i = 0; i < NUM_LINES; i++) begin
            line_valid[i] = 1'b0;
        end
        repeat (2) @(posedge clk_i);
        rst_n_i <= 1'b1;

        start_test("cold_miss");
        do_load(32'h0000_1234, kind);
        check_val("load outcome", MISS, kind);
        check_val("handshakes", 1, hs_count);
        check_val("mmu_addr_o", 32'h0000_1230, last_req_addr);
        end_test();

        start_test("repeat_hit");
        hs_at = hs_count;
        do_load(32'h0000_1238, kind);
        check_val("load outcome", HIT, kind);
        check_val("handshakes", hs_at, hs_count);
        end_test();

        start_test("store_forward");
        @(posedge clk_i);
        flush_permit_i <= 1'b0;
        do_store(32'h0000_2040, 32'hA5A5_0001, stalls);
        do_load(32'h0000_2040, kind);
        check_val("load outcome", FWD, kind);
        check_val("forwarded data", 32'hA5A5_0001, load_data_o);
        do_store(32'h0000_2040, 32'h5A5A_0002, stalls);
        do_load(32'h0000_2040, kind);
        check_val("youngest data", 32'h5A5A_0002, load_data_o);
        wait_drained();
        end_test();

        start_test("drain_order");
        flushes_at = flush_total;
        @(posedge clk_i);
        flush_permit_i <= 1'b0;
        for (int i = 0; i < 3; i++) begin
            do_store(addr_t'(32'h3000 + 16 * i), word_t'(32'hC0DE_0000 + i), stalls);
        end
        wait_drained();
        check_val("flush count", 3, flush_total - flushes_at);
        end_test();

        // Fill the buffer so the extra store has to wait for a drain
        start_test("full_stall");
        @(posedge clk_i);
        flush_permit_i <= 1'b0;
        for (int i = 0; i < `TL_SB_DEPTH; i++) begin
            do_store(addr_t'(32'h4000 + 4 * i), word_t'(32'hF000 + i), stalls);
            check_val("stall cycles", 0, stalls);
        end
        do_store(32'h0000_4100, 32'hBEEF_0005, stalls);
        check_val("stall cycles", UNBLOCK_AT + 1, stalls);
        wait_drained();
        end_test();

        start_test("random_mix");
        for (int n = 0; n < 200; n++) begin
            r = lcg_next(main_seed);
            a = addr_t'({r[15:9], 2'b00});
            d = {lcg_next(main_seed), r};
            @(posedge clk_i);
            flush_permit_i <= r[2];
            case (r[1:0])
                2'd0, 2'd1: do_load(a, kind);
                2'd2:       do_store(a, d, stalls);
                default:    @(negedge clk_i);
            endcase
        end
        wait_drained();
        check_val("handshakes", miss_count, hs_count);
        end_test();

        err_count = err_count + tl_stage_inst.tl_stage_sva_inst.fail_count;
        $display("tests passed %0d of %0d, errors %0d", pass_count, test_count, err_count);
        if (err_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+include
rtl/mem_types_pkg.sv
rtl/tl_ctrl_pkg.sv
rtl/dcache_tag.sv
rtl/sb_alloc.sv
rtl/sb_entry.sv
rtl/sb_drain.sv
rtl/tl_stage.sv
bench/tl_stage_sva.sv
bench/tl_stage_tb.sv

// ==== Makefile ====
# Verilator build and run for the tag-lookup stage testbench

VERILATOR ?= verilator
TOP       ?= tl_stage_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
RUN_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Done: no errors

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$($(SIM) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
